// File: Bender.yml
package:
  name: soc_board

dependencies: {}

sources:
  - soc_bus_pkg.sv
  - soc_board_pkg.sv
  - rst_sync.sv
  - dmi_bridge.sv
  - bus_decoder.sv
  - sram_mem.sv
  - gpio_ctrl.sv
  - soc_board_top.sv
  - target: simulation
    files:
      - tb_soc_board.sv

// File: bus_decoder.sv
// Memory bus decoder for the RAM and GPIO targets
// Unmapped accesses get an error response from here

`timescale 1ns/1ps

module bus_decoder (
   input  logic                  clk_core,
   input  logic                  i_rst_n,
   input  soc_bus_pkg::bus_req_t i_req,
   output soc_bus_pkg::bus_rsp_t o_rsp,
   output soc_bus_pkg::bus_req_t o_ram_req,
   input  soc_bus_pkg::bus_rsp_t i_ram_rsp,
   output soc_bus_pkg::bus_req_t o_gpio_req,
   input  soc_bus_pkg::bus_rsp_t i_gpio_rsp
);

   import soc_bus_pkg::*;
   import soc_board_pkg::*;

   bus_addr_t ram_ofs;
   bus_addr_t gpio_ofs;
   logic      ram_hit;
   logic      gpio_hit;
   logic      unmapped_q;

   // Addresses below a base wrap to large offsets and miss
   assign ram_ofs  = i_req.addr - RAM_BASE;
   assign gpio_ofs = i_req.addr - GPIO_BASE;
   assign ram_hit  = ram_ofs < bus_addr_t'(RAM_WORDS * 4);
   assign gpio_hit = gpio_ofs < (GPIO_SW_OFS + 32'd4);

   always_comb begin
      o_ram_req        = i_req;
      o_ram_req.valid  = i_req.valid & ram_hit;
      o_ram_req.addr   = ram_ofs;
      o_gpio_req       = i_req;
      o_gpio_req.valid = i_req.valid & gpio_hit;
      o_gpio_req.addr  = gpio_ofs;
   end

   // Error response one cycle after an unmapped request
   always_ff @(posedge clk_core or negedge i_rst_n) begin
      if (!i_rst_n) begin
         unmapped_q <= 1'b0;
      end else begin
         unmapped_q <= i_req.valid & ~ram_hit & ~gpio_hit;
      end
   end

   // Only one target answers per access, so an OR merges them
   always_comb begin
      o_rsp.valid = i_ram_rsp.valid | i_gpio_rsp.valid | unmapped_q;
      o_rsp.err   = (i_ram_rsp.valid & i_ram_rsp.err)
                  | (i_gpio_rsp.valid & i_gpio_rsp.err)
                  | unmapped_q;
      o_rsp.rdata = (i_ram_rsp.valid ? i_ram_rsp.rdata : '0)
                  | (i_gpio_rsp.valid ? i_gpio_rsp.rdata : '0);
   end

endmodule

// File: dmi_bridge.sv
// DMI register file that launches single memory bus accesses
// Holds ADDR, WDATA, CMD, RDATA and STATUS for the debug port

`timescale 1ns/1ps

module dmi_bridge (
   input  logic                   clk_core,
   input  logic                   i_rst_n,
   input  soc_bus_pkg::dmi_req_t  i_dmi,
   output soc_bus_pkg::bus_data_t o_dmi_rdata,
   output soc_bus_pkg::bus_req_t  o_req,
   input  soc_bus_pkg::bus_rsp_t  i_rsp
);

   import soc_bus_pkg::*;
   import soc_board_pkg::*;

   typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} state_t;

   state_t    state_q;
   bus_addr_t addr_q;
   bus_data_t wdata_q;
   bus_data_t cmd_q;
   bus_data_t rdata_q;
   bus_data_t status;
   logic      err_q;
   logic      rsp_valid_q;
   logic      rsp_err_q;
   bus_data_t rsp_rdata_q;
   logic      busy;
   logic      dmi_wr;
   logic      wr_cmd;
   logic      start;
   logic      done;

   assign busy   = (state_q != ST_IDLE);
   assign dmi_wr = i_dmi.en & i_dmi.wr_en;
   assign wr_cmd = dmi_wr && (i_dmi.addr == DMI_CMD);
   assign start  = wr_cmd & ~busy;
   // Response has been registered for a cycle
   assign done   = (state_q == ST_WAIT) & rsp_valid_q;

   // ********************
   // Control registers
   // ********************

   always_ff @(posedge clk_core or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q     <= ST_IDLE;
         addr_q      <= '0;
         wdata_q     <= '0;
         cmd_q       <= '0;
         err_q       <= 1'b0;
         rsp_valid_q <= 1'b0;
      end else begin
         rsp_valid_q <= i_rsp.valid;
         case (state_q)
            ST_IDLE: if (start) state_q <= ST_REQ;
            ST_REQ:  state_q <= ST_WAIT;
            ST_WAIT: if (rsp_valid_q) state_q <= ST_IDLE;
            default: state_q <= ST_IDLE;
         endcase
         // Auto-increment walks the address one word per access
         if (done && cmd_q[CMD_INC_BIT]) addr_q <= addr_q + 32'd4;
         if (dmi_wr && (i_dmi.addr == DMI_ADDR)) addr_q <= i_dmi.wdata;
         if (dmi_wr && (i_dmi.addr == DMI_WDATA)) wdata_q <= i_dmi.wdata;
         if (start) cmd_q <= i_dmi.wdata;
         // Clear first so a new error in the same cycle survives
         if (dmi_wr && (i_dmi.addr == DMI_STATUS) && i_dmi.wdata[STAT_ERR_BIT]) begin
            err_q <= 1'b0;
         end
         if ((wr_cmd && busy) || (done && rsp_err_q)) err_q <= 1'b1;
      end
   end

   // Response payload and result
   always_ff @(posedge clk_core) begin
      rsp_err_q   <= i_rsp.err;
      rsp_rdata_q <= i_rsp.rdata;
      if (done) rdata_q <= rsp_rdata_q;
   end

   // ********************
   // Bus request and DMI read
   // ********************

   always_comb begin
      o_req.valid = (state_q == ST_REQ);
      o_req.we    = cmd_q[CMD_WE_BIT];
      o_req.addr  = addr_q;
      o_req.wdata = wdata_q;
      o_req.strb  = cmd_q[CMD_STRB_LSB +: 4];
   end

   always_comb begin
      status                = '0;
      status[STAT_BUSY_BIT] = busy;
      status[STAT_ERR_BIT]  = err_q;
      case (i_dmi.addr)
         DMI_ADDR:   o_dmi_rdata = addr_q;
         DMI_WDATA:  o_dmi_rdata = wdata_q;
         DMI_CMD:    o_dmi_rdata = cmd_q;
         DMI_RDATA:  o_dmi_rdata = rdata_q;
         DMI_STATUS: o_dmi_rdata = status;
         default:    o_dmi_rdata = '0;
      endcase
   end

endmodule

// File: gpio_ctrl.sv
// GPIO registers for the board LEDs and switches
// LEDs leave through two register stages, switches enter through two flops

`timescale 1ns/1ps

module gpio_ctrl (
   input  logic                     clk_core,
   input  logic                     i_rst_n,
   input  soc_bus_pkg::bus_req_t    i_req,
   output soc_bus_pkg::bus_rsp_t    o_rsp,
   input  soc_board_pkg::gpio_vec_t i_sw,
   output soc_board_pkg::gpio_vec_t o_led
);

   import soc_bus_pkg::*;
   import soc_board_pkg::*;

   gpio_vec_t led_q;
   gpio_vec_t sw_meta;
   gpio_vec_t sw_sync;
   bus_data_t rdata_q;
   logic      valid_q;
   logic      sel_led;
   logic      sel_sw;

   // Word compare, byte offset bits ignored
   assign sel_led = (i_req.addr[31:2] == GPIO_LED_OFS[31:2]);
   assign sel_sw  = (i_req.addr[31:2] == GPIO_SW_OFS[31:2]);

   always_ff @(posedge clk_core or negedge i_rst_n) begin
      if (!i_rst_n) begin
         led_q   <= '0;
         o_led   <= '0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= i_req.valid;
         o_led   <= led_q;
         // Switch offset takes no writes
         if (i_req.valid && i_req.we && sel_led) begin
            for (int b = 0; b < GPIO_WIDTH/8; b++) begin
               if (i_req.strb[b]) led_q[8*b +: 8] <= i_req.wdata[8*b +: 8];
            end
         end
      end
   end

   // Switch synchroniser and read data
   always_ff @(posedge clk_core) begin
      sw_meta <= i_sw;
      sw_sync <= sw_meta;
      if (i_req.valid) begin
         if (sel_led)     rdata_q <= bus_data_t'(led_q);
         else if (sel_sw) rdata_q <= bus_data_t'(sw_sync);
         else             rdata_q <= '0;
      end
   end

   always_comb begin
      o_rsp.valid = valid_q;
      o_rsp.err   = 1'b0;
      o_rsp.rdata = rdata_q;
   end

endmodule

// File: list.f
soc_bus_pkg.sv
soc_board_pkg.sv
rst_sync.sv
dmi_bridge.sv
bus_decoder.sv
sram_mem.sv
gpio_ctrl.sv
soc_board_top.sv
tb_soc_board.sv

// File: rst_sync.sv
// Reset synchroniser for the core clock
// Asserts at once, releases two clock edges after the input rises

`timescale 1ns/1ps

module rst_sync (
   input  logic clk_core,
   input  logic i_arst_n,
   output logic o_rst_n
);

   logic rst_meta_n;
   logic rst_sync_n;

   // Chain fills with ones once the board reset is gone
   always_ff @(posedge clk_core or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rst_meta_n <= 1'b0;
         rst_sync_n <= 1'b0;
      end else begin
         rst_meta_n <= 1'b1;
         rst_sync_n <= rst_meta_n;
      end
   end

   assign o_rst_n = rst_sync_n;

endmodule

// File: soc_board_pkg.sv
// Board address map, DMI register map and GPIO widths

package soc_board_pkg;

   // Address map
   localparam soc_bus_pkg::bus_addr_t RAM_BASE     = 32'h0000_0000;
   localparam int                     RAM_WORDS    = 256;
   localparam soc_bus_pkg::bus_addr_t GPIO_BASE    = 32'h8000_0000;
   localparam soc_bus_pkg::bus_addr_t GPIO_LED_OFS = 32'h0000_0000;
   localparam soc_bus_pkg::bus_addr_t GPIO_SW_OFS  = 32'h0000_0004;

   // Board I/O
   localparam int GPIO_WIDTH = 16;
   typedef logic [GPIO_WIDTH-1:0] gpio_vec_t;

   // DMI register numbers
   localparam soc_bus_pkg::dmi_addr_t DMI_ADDR   = 7'h10;
   localparam soc_bus_pkg::dmi_addr_t DMI_WDATA  = 7'h11;
   localparam soc_bus_pkg::dmi_addr_t DMI_CMD    = 7'h12;
   localparam soc_bus_pkg::dmi_addr_t DMI_RDATA  = 7'h13;
   localparam soc_bus_pkg::dmi_addr_t DMI_STATUS = 7'h14;

   // CMD and STATUS fields
   localparam int CMD_WE_BIT    = 0;
   localparam int CMD_INC_BIT   = 1;
   localparam int CMD_STRB_LSB  = 4;
   localparam int STAT_BUSY_BIT = 0;
   localparam int STAT_ERR_BIT  = 1;

endpackage

// File: soc_board_top.sv
// Board top level for the DMI driven SoC shell
// Connects reset, DMI bridge, bus decoder, RAM and GPIO

`timescale 1ns/1ps

module soc_board_top (
   input  logic                     clk_core,
   input  logic                     i_arst_n,
   input  soc_bus_pkg::dmi_req_t    i_dmi,
   output soc_bus_pkg::bus_data_t   o_dmi_rdata,
   input  soc_board_pkg::gpio_vec_t i_sw,
   output soc_board_pkg::gpio_vec_t o_led
);

   import soc_bus_pkg::*;

   logic     rst_n;

   // ********************
   // Bus wiring
   // ********************

   bus_req_t bridge_req;
   bus_rsp_t bridge_rsp;
   bus_req_t ram_req;
   bus_rsp_t ram_rsp;
   bus_req_t gpio_req;
   bus_rsp_t gpio_rsp;

   rst_sync rst_sync_i (
      .clk_core (clk_core),
      .i_arst_n (i_arst_n),
      .o_rst_n  (rst_n)
   );

   // Debug port stands in for the core as bus master
   dmi_bridge dmi_bridge_i (
      .clk_core    (clk_core),
      .i_rst_n     (rst_n),
      .i_dmi       (i_dmi),
      .o_dmi_rdata (o_dmi_rdata),
      .o_req       (bridge_req),
      .i_rsp       (bridge_rsp)
   );

   bus_decoder bus_decoder_i (
      .clk_core   (clk_core),
      .i_rst_n    (rst_n),
      .i_req      (bridge_req),
      .o_rsp      (bridge_rsp),
      .o_ram_req  (ram_req),
      .i_ram_rsp  (ram_rsp),
      .o_gpio_req (gpio_req),
      .i_gpio_rsp (gpio_rsp)
   );

   // ********************
   // Targets
   // ********************

   sram_mem sram_mem_i (
      .clk_core (clk_core),
      .i_req    (ram_req),
      .o_rsp    (ram_rsp)
   );

   gpio_ctrl gpio_ctrl_i (
      .clk_core (clk_core),
      .i_rst_n  (rst_n),
      .i_req    (gpio_req),
      .o_rsp    (gpio_rsp),
      .i_sw     (i_sw),
      .o_led    (o_led)
   );

endmodule

// File: soc_bus_pkg.sv
// Internal memory bus and DMI port types
// Shared by the bridge, the decoder and the bus targets

package soc_bus_pkg;

   // ********************
   // Memory bus
   // ********************

   typedef logic [31:0] bus_addr_t;
   typedef logic [31:0] bus_data_t;
   typedef logic [3:0]  bus_strb_t;

   // Request from the bridge, one cycle strobe with no ready
   typedef struct packed {
      logic      valid;
      logic      we;
      bus_addr_t addr;
      bus_data_t wdata;
      bus_strb_t strb;
   } bus_req_t;

   // Response, always one cycle after the request
   typedef struct packed {
      logic      valid;
      logic      err;
      bus_data_t rdata;
   } bus_rsp_t;

   // ********************
   // DMI register port
   // ********************

   typedef logic [6:0] dmi_addr_t;

   typedef struct packed {
      logic      en;
      logic      wr_en;
      dmi_addr_t addr;
      bus_data_t wdata;
   } dmi_req_t;

endpackage

// File: sram_mem.sv
// Single-port word RAM with byte strobes
// Answers every access one edge after the request

`timescale 1ns/1ps

module sram_mem #(
   parameter int WORDS = soc_board_pkg::RAM_WORDS
) (
   input  logic                  clk_core,
   input  soc_bus_pkg::bus_req_t i_req,
   output soc_bus_pkg::bus_rsp_t o_rsp
);

   import soc_bus_pkg::*;

   bus_data_t                   mem [WORDS];
   bus_data_t                   rdata_q;
   logic                        valid_q;
   logic [$clog2(WORDS)-1:0]    idx;

   // Word index from the byte offset
   assign idx = i_req.addr[2 +: $clog2(WORDS)];

   always_ff @(posedge clk_core) begin
      if (i_req.valid) begin
         if (i_req.we) begin
            for (int b = 0; b < 4; b++) begin
               if (i_req.strb[b]) mem[idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
            end
         end
         rdata_q <= mem[idx];
      end
   end

   // Response valid follows the request by one edge
   always_ff @(posedge clk_core) begin
      valid_q <= i_req.valid;
   end

   always_comb begin
      o_rsp.valid = valid_q;
      o_rsp.err   = 1'b0;
      o_rsp.rdata = rdata_q;
   end

endmodule

// File: tb_soc_board.sv
// Directed testbench for the DMI driven SoC board shell
// Exercises RAM, GPIO and error paths through the debug register port

`timescale 1ns/1ps

module tb_soc_board;

   import soc_bus_pkg::*;
   import soc_board_pkg::*;

   localparam int POLL_LIMIT = 20;

   logic        clk_core;
   logic        i_arst_n;
   dmi_req_t    i_dmi;
   bus_data_t   o_dmi_rdata;
   gpio_vec_t   i_sw;
   gpio_vec_t   o_led;
   logic [15:0] lfsr_q;
   bus_data_t   ref_mem [RAM_WORDS];
   int          used_idx [16];
   int          error_count;
   int          check_count;

   soc_board_top soc_board_top_i (
      .clk_core    (clk_core),
      .i_arst_n    (i_arst_n),
      .i_dmi       (i_dmi),
      .o_dmi_rdata (o_dmi_rdata),
      .i_sw        (i_sw),
      .o_led       (o_led)
   );

   always #20 clk_core = ~clk_core;

   // ********************
   // Stimulus helpers
   // ********************

   // Taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic bus_data_t random_bits(input int nbits);
      bus_data_t v;
      v = '0;
      for (int i = 0; i < nbits; i++) begin
         v      = {v[30:0], lfsr_q[15]};
         lfsr_q = lfsr_next(lfsr_q);
      end
      return v;
   endfunction

   function automatic bus_data_t make_cmd(input logic we, input logic inc, input bus_strb_t strb);
      bus_data_t c;
      c                    = '0;
      c[CMD_WE_BIT]        = we;
      c[CMD_INC_BIT]       = inc;
      c[CMD_STRB_LSB +: 4] = strb;
      return c;
   endfunction

   // Reference byte merge for strobed writes
   function automatic bus_data_t merge_bytes(input bus_data_t old_w, input bus_data_t new_w,
                                             input bus_strb_t strb);
      bus_data_t m;
      m = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            m[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return m;
   endfunction

   task automatic compare_data(input string name, input bus_data_t got, input bus_data_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic compare_led(input string name, input gpio_vec_t got, input gpio_vec_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("MISMATCH %s: got 0x%04h, expected 0x%04h", name, got, exp);
      end
   endtask

   task automatic compare_status(input string name, input bus_data_t got, input bus_data_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   // ********************
   // DMI driver
   // ********************

   task automatic dmi_write(input dmi_addr_t addr, input bus_data_t data);
      dmi_req_t req;
      req = '{en: 1'b1, wr_en: 1'b1, addr: addr, wdata: data};
      @(posedge clk_core);
      i_dmi <= req;
      @(posedge clk_core);
      i_dmi <= '0;
   endtask

   // Read data is combinational, sampled mid-cycle
   task automatic dmi_read(input dmi_addr_t addr, output bus_data_t data);
      dmi_req_t req;
      req = '{en: 1'b1, wr_en: 1'b0, addr: addr, wdata: '0};
      @(posedge clk_core);
      i_dmi <= req;
      @(negedge clk_core);
      data = o_dmi_rdata;
   endtask

   task automatic wait_idle(output bus_data_t status);
      int polls;
      polls = 0;
      dmi_read(DMI_STATUS, status);
      while (status[STAT_BUSY_BIT] !== 1'b0 && polls < POLL_LIMIT) begin
         polls++;
         dmi_read(DMI_STATUS, status);
      end
      if (status[STAT_BUSY_BIT] !== 1'b0) begin
         error_count++;
         $display("ERROR: bus access still busy after %0d STATUS polls", POLL_LIMIT);
      end
   endtask

   task automatic bus_access(input bus_addr_t addr, input bus_data_t wdata, input bus_data_t cmd,
                             output bus_data_t rdata, output bus_data_t status);
      dmi_write(DMI_ADDR, addr);
      dmi_write(DMI_WDATA, wdata);
      dmi_write(DMI_CMD, cmd);
      wait_idle(status);
      dmi_read(DMI_RDATA, rdata);
   endtask

   task automatic wait_led(input gpio_vec_t exp);
      int cycles;
      cycles = 0;
      @(negedge clk_core);
      while (o_led !== exp && cycles < POLL_LIMIT) begin
         cycles++;
         @(negedge clk_core);
      end
   endtask

   // ********************
   // Directed tests
   // ********************

   task automatic test_reset_values();
      bus_data_t v;
      dmi_read(DMI_STATUS, v);
      compare_status("STATUS", v, '0);
      dmi_read(DMI_ADDR, v);
      compare_data("ADDR", v, '0);
      dmi_read(DMI_WDATA, v);
      compare_data("WDATA", v, '0);
      dmi_read(DMI_CMD, v);
      compare_data("CMD", v, '0);
      dmi_read(7'h05, v);
      compare_data("unknown DMI register", v, '0);
      compare_led("o_led", o_led, '0);
   endtask

   task automatic test_ram_words();
      bus_data_t wdata;
      bus_data_t rdata;
      bus_data_t status;
      int        idx;
      for (int i = 0; i < 16; i++) begin
         idx          = int'(random_bits($clog2(RAM_WORDS)));
         wdata        = random_bits(32);
         used_idx[i]  = idx;
         ref_mem[idx] = wdata;
         bus_access(RAM_BASE + bus_addr_t'(idx * 4), wdata, make_cmd(1'b1, 1'b0, 4'hF),
                    rdata, status);
         compare_status("STATUS", status, '0);
      end
      for (int i = 0; i < 16; i++) begin
         idx = used_idx[i];
         bus_access(RAM_BASE + bus_addr_t'(idx * 4), '0, make_cmd(1'b0, 1'b0, 4'h0),
                    rdata, status);
         compare_data("RDATA", rdata, ref_mem[idx]);
      end
   endtask

   task automatic test_strobes_and_blocks();
      bus_data_t wdata;
      bus_data_t rdata;
      bus_data_t status;
      bus_strb_t strb;
      bus_addr_t base;
      int        idx;
      for (int i = 0; i < 8; i++) begin
         idx          = used_idx[i];
         strb         = bus_strb_t'(random_bits(4));
         wdata        = random_bits(32);
         ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, strb);
         bus_access(RAM_BASE + bus_addr_t'(idx * 4), wdata, make_cmd(1'b1, 1'b0, strb),
                    rdata, status);
         bus_access(RAM_BASE + bus_addr_t'(idx * 4), '0, make_cmd(1'b0, 1'b0, 4'h0),
                    rdata, status);
         compare_data("RDATA", rdata, ref_mem[idx]);
      end
      // Block of 8 words from index 0xC0, written then read with auto-increment
      base = RAM_BASE + bus_addr_t'(32'hC0 * 4);
      dmi_write(DMI_ADDR, base);
      for (int i = 0; i < 8; i++) begin
         wdata               = random_bits(32);
         ref_mem[32'hC0 + i] = wdata;
         dmi_write(DMI_WDATA, wdata);
         dmi_write(DMI_CMD, make_cmd(1'b1, 1'b1, 4'hF));
         wait_idle(status);
      end
      dmi_read(DMI_ADDR, rdata);
      compare_data("ADDR", rdata, base + 32'd32);
      dmi_write(DMI_ADDR, base);
      for (int i = 0; i < 8; i++) begin
         dmi_write(DMI_CMD, make_cmd(1'b0, 1'b1, 4'h0));
         wait_idle(status);
         dmi_read(DMI_RDATA, rdata);
         compare_data("RDATA", rdata, ref_mem[32'hC0 + i]);
      end
      dmi_read(DMI_ADDR, rdata);
      compare_data("ADDR", rdata, base + 32'd32);
   endtask

   task automatic test_led();
      gpio_vec_t led;
      bus_data_t wdata;
      bus_data_t rdata;
      bus_data_t status;
      led = gpio_vec_t'(random_bits(16));
      bus_access(GPIO_BASE + GPIO_LED_OFS, bus_data_t'(led), make_cmd(1'b1, 1'b0, 4'h3),
                 rdata, status);
      compare_status("STATUS", status, '0);
      wait_led(led);
      compare_led("o_led", o_led, led);
      bus_access(GPIO_BASE + GPIO_LED_OFS, '0, make_cmd(1'b0, 1'b0, 4'h0), rdata, status);
      compare_data("RDATA", rdata, bus_data_t'(led));
      // Upper LED byte only
      wdata = random_bits(32);
      led   = {wdata[15:8], led[7:0]};
      bus_access(GPIO_BASE + GPIO_LED_OFS, wdata, make_cmd(1'b1, 1'b0, 4'b0010), rdata, status);
      wait_led(led);
      compare_led("o_led", o_led, led);
   endtask

   task automatic test_switches();
      gpio_vec_t sw;
      bus_data_t rdata;
      bus_data_t status;
      sw = gpio_vec_t'(random_bits(16));
      @(posedge clk_core);
      i_sw <= sw;
      // Two synchroniser flops before the value is readable
      repeat (3) @(posedge clk_core);
      bus_access(GPIO_BASE + GPIO_SW_OFS, '0, make_cmd(1'b0, 1'b0, 4'h0), rdata, status);
      compare_data("RDATA", rdata, bus_data_t'(sw));
      bus_access(GPIO_BASE + GPIO_SW_OFS, 32'hFFFF_FFFF, make_cmd(1'b1, 1'b0, 4'hF),
                 rdata, status);
      compare_status("STATUS", status, '0);
      bus_access(GPIO_BASE + GPIO_SW_OFS, '0, make_cmd(1'b0, 1'b0, 4'h0), rdata, status);
      compare_data("RDATA", rdata, bus_data_t'(sw));
   endtask

   task automatic test_errors();
      bus_data_t err_stat;
      bus_data_t cmd;
      bus_data_t rdata;
      bus_data_t status;
      err_stat               = '0;
      err_stat[STAT_ERR_BIT] = 1'b1;
      bus_access(32'h4000_0000, '0, make_cmd(1'b0, 1'b0, 4'h0), rdata, status);
      compare_status("STATUS", status, err_stat);
      compare_data("RDATA", rdata, '0);
      dmi_write(DMI_STATUS, err_stat);
      dmi_read(DMI_STATUS, status);
      compare_status("STATUS", status, '0);
      // Second CMD lands while the first access is in flight
      cmd = make_cmd(1'b0, 1'b0, 4'h0);
      dmi_write(DMI_ADDR, RAM_BASE + bus_addr_t'(used_idx[0] * 4));
      dmi_write(DMI_CMD, cmd);
      dmi_write(DMI_CMD, make_cmd(1'b1, 1'b0, 4'hF));
      wait_idle(status);
      compare_status("STATUS", status, err_stat);
      dmi_read(DMI_CMD, rdata);
      compare_data("CMD", rdata, cmd);
      dmi_write(DMI_STATUS, err_stat);
      dmi_read(DMI_STATUS, status);
      compare_status("STATUS", status, '0);
   endtask

   initial begin
      clk_core    = 1'b0;
      i_arst_n    = 1'b0;
      i_dmi       = '0;
      i_sw        = '0;
      lfsr_q      = 16'd44707;
      error_count = 0;
      check_count = 0;
      repeat (8) @(posedge clk_core);
      i_arst_n <= 1'b1;
      // Internal reset releases two edges later
      repeat (3) @(posedge clk_core);
      test_reset_values();
      test_ram_words();
      test_strobes_and_blocks();
      test_led();
      test_switches();
      test_errors();
      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule
